// ==== hdl/mtxPkg.sv ====
// Matrix format definitions for the 4x4 inverter
// Q20.12 signed elements, wide intermediates and the packed
// row-major matrix used on the top level ports

package mtxPkg;

    // ========================================
    // Matrix geometry
    // ========================================
    localparam int matDim   = 4;                // Matrix order
    localparam int matElems = matDim * matDim;  // Elements per matrix

    // ========================================
    // Fixed point format
    // ========================================
    localparam int elemWidth = 32;              // Q20.12 element width
    localparam int fracBits  = 12;              // Fraction bits
    localparam int wideWidth = 2 * elemWidth;   // Product and numerator width
    localparam int qOne      = 1 << fracBits;   // 1.0 in Q20.12, 4096

    // One signed matrix element
    typedef logic signed [elemWidth-1:0] qElem_t;

    // Full precision product or pre-shifted dividend
    typedef logic signed [wideWidth-1:0] qWide_t;

    // Packed matrix, element (row, col) at index row*matDim+col
    // Index 0 lands in the low 32 bits, 512 bits in total
    typedef logic [matElems-1:0][elemWidth-1:0] matFlat_t;

endpackage

// ==== hdl/ctlPkg.sv ====
// Control definitions for the 4x4 inverter
// FSM state encoding, ALU mode select and the 2-bit
// row and column index shared by controller and datapath

package ctlPkg;

    // Sequencer states
    typedef enum logic [3:0] {
        IDLE,       // Waiting for start
        LOAD,       // Matrix captured, counters reset
        PIVOT,      // Pivot search and row swap
        LATCHP,     // Latch pivot value
        NORM,       // Normalize pivot row, one column per cycle
        LATCHF,     // Latch elimination factor
        ELIM,       // Eliminate target row, one column per cycle
        FINISH,     // Capture result
        DONE        // Result valid until start drops
    } ctlState_t;

    // Row ALU mode
    typedef enum logic {
        opNorm = 1'b0,  // Divide by pivot
        opElim = 1'b1   // Multiply-subtract with factor
    } aluOp_t;

    // Row or column index
    typedef logic [1:0] idx_t;

    localparam idx_t idxLast = 2'd3;  // Highest row or column

endpackage

// ==== hdl/invControl.sv ====
// Sequencer for the Gauss-Jordan inverter
// Walks load, pivot, normalize and eliminate per column and
// leaves early to DONE when no pivot exists

`timescale 1ns/1ps

module invControl (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           pivotFound,   // Nonzero entry at or below diagonal
    input  logic           kLast,        // Last element column
    input  logic           rowLast,      // Last target row of this pivot
    input  logic           colLast,      // Last pivot column
    output logic           load,
    output logic           swap,
    output logic           latchPivot,
    output logic           latchFactor,
    output logic           wrEn,
    output logic           capture,
    output logic           singularOut,
    output logic           cntClear,
    output logic           kStep,
    output logic           rowStep,
    output logic           colStep,
    output logic           done,
    output ctlPkg::aluOp_t aluOp
);
    import ctlPkg::*;

    ctlState_t state, stateNext;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        stateNext = state;
        case (state)
            IDLE:   if (start) stateNext = LOAD;
            LOAD:   stateNext = PIVOT;
            PIVOT:  stateNext = pivotFound ? LATCHP : DONE;  // Singular exits here
            LATCHP: stateNext = NORM;
            NORM:   if (kLast) stateNext = LATCHF;
            LATCHF: stateNext = ELIM;
            ELIM: begin
                if (kLast) begin
                    if (!rowLast)
                        stateNext = LATCHF;   // Next target row
                    else if (colLast)
                        stateNext = FINISH;
                    else
                        stateNext = PIVOT;    // Next pivot column
                end
            end
            FINISH: stateNext = DONE;
            DONE:   if (!start) stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= stateNext;
            done  <= (stateNext == DONE);  // High exactly while in DONE
        end
    end

    // ========================================
    // Strobes, decoded from state
    // ========================================
    assign load        = (state == IDLE) && start;   // Sample matrixIn on accept
    assign cntClear    = (state == LOAD);
    assign swap        = (state == PIVOT) && pivotFound;
    assign singularOut = (state == PIVOT) && !pivotFound;
    assign latchPivot  = (state == LATCHP);
    assign latchFactor = (state == LATCHF);
    assign wrEn        = (state == NORM) || (state == ELIM);
    assign kStep       = wrEn;                       // One element column per write
    assign rowStep     = (state == ELIM) && kLast;
    assign colStep     = rowStep && rowLast;
    assign capture     = (state == FINISH) || singularOut;  // On entry to DONE

    // Pivot row work uses normalize, everything else eliminate
    assign aluOp = ((state == LATCHF) || (state == ELIM)) ? opElim : opNorm;

    // Row passes begin at element column 0
    assert property (@(posedge clk) disable iff (rst) (latchPivot || latchFactor) |-> !kLast);

endmodule

// ==== hdl/indexCounter.sv ====
// Index counters for the inverter
// Pivot column, target row and element column with end flags
// Target row steps over the pivot row

`timescale 1ns/1ps

module indexCounter (
    input  logic         clk,
    input  logic         rst,
    input  logic         cntClear,
    input  logic         kStep,
    input  logic         rowStep,
    input  logic         colStep,
    output ctlPkg::idx_t pivotCol,
    output ctlPkg::idx_t targetRow,
    output ctlPkg::idx_t elemCol,
    output logic         kLast,
    output logic         rowLast,
    output logic         colLast
);
    import ctlPkg::*;

    idx_t nextPivot, nextRow;

    always_comb begin
        nextPivot = idx_t'(pivotCol + 2'd1);
        nextRow   = idx_t'(targetRow + 2'd1);
        if (nextRow == pivotCol)
            nextRow = idx_t'(nextRow + 2'd1);  // Skip the pivot row
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pivotCol  <= '0;
            targetRow <= 2'd1;
            elemCol   <= '0;
        end else if (cntClear) begin
            pivotCol  <= '0;
            targetRow <= 2'd1;       // First row other than row 0
            elemCol   <= '0;
        end else begin
            if (kStep)
                elemCol <= idx_t'(elemCol + 2'd1);  // Wraps to 0 after last
            if (colStep) begin
                pivotCol  <= nextPivot;
                targetRow <= (nextPivot == '0) ? 2'd1 : 2'd0;
            end else if (rowStep) begin
                targetRow <= nextRow;
            end
        end
    end

    // End flags
    assign kLast   = (elemCol == idxLast);
    assign colLast = (pivotCol == idxLast);
    assign rowLast = (targetRow == (colLast ? idx_t'(idxLast - 2'd1) : idxLast));

endmodule

// ==== hdl/augMatrix.sv ====
// Augmented A|I register file
// Loads A and identity, finds the pivot row, swaps rows,
// writes ALU results back and registers the packed result

`timescale 1ns/1ps

module augMatrix (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic             swap,
    input  logic             wrEn,
    input  logic             capture,
    input  logic             singularOut,
    input  ctlPkg::aluOp_t   aluOp,
    input  mtxPkg::matFlat_t matrixIn,
    input  ctlPkg::idx_t     pivotCol,
    input  ctlPkg::idx_t     targetRow,
    input  ctlPkg::idx_t     elemCol,
    input  mtxPkg::qElem_t   aNew,
    input  mtxPkg::qElem_t   iNew,
    output logic             pivotFound,
    output mtxPkg::qElem_t   diagElem,    // A[c][c]
    output mtxPkg::qElem_t   colElem,     // A[r][c]
    output mtxPkg::qElem_t   srcA,        // Pivot row element k
    output mtxPkg::qElem_t   srcI,
    output mtxPkg::qElem_t   dstA,        // Element k of the row being written
    output mtxPkg::qElem_t   dstI,
    output mtxPkg::matFlat_t matrixOut,
    output logic             singular
);
    import mtxPkg::*;
    import ctlPkg::*;

    qElem_t aMat [matElems];  // Left half, the matrix being reduced
    qElem_t iMat [matElems];  // Right half, becomes the inverse
    idx_t   pivotRow;
    idx_t   rowSel;

    // Flat index of (row, col), row-major with matDim = 4
    function automatic logic [3:0] elemAt(idx_t row, idx_t col);
        return {row, col};
    endfunction

    // ========================================
    // Pivot search
    // ========================================
    // Descending scan so the smallest qualifying row wins
    always_comb begin
        pivotFound = 1'b0;
        pivotRow   = pivotCol;
        for (int r = matDim - 1; r >= 0; r--) begin
            if ((r >= pivotCol) && (aMat[elemAt(idx_t'(r), pivotCol)] != '0)) begin
                pivotFound = 1'b1;
                pivotRow   = idx_t'(r);
            end
        end
    end

    // Write row is the pivot row when normalizing
    assign rowSel = (aluOp == opElim) ? targetRow : pivotCol;

    // ALU operands
    assign diagElem = aMat[elemAt(pivotCol, pivotCol)];
    assign colElem  = aMat[elemAt(targetRow, pivotCol)];
    assign srcA     = aMat[elemAt(pivotCol, elemCol)];
    assign srcI     = iMat[elemAt(pivotCol, elemCol)];
    assign dstA     = aMat[elemAt(rowSel, elemCol)];
    assign dstI     = iMat[elemAt(rowSel, elemCol)];

    // ========================================
    // Storage
    // ========================================
    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < matElems; i++) begin
                aMat[i] <= matrixIn[i];
                iMat[i] <= ((i / matDim) == (i % matDim)) ? qOne : '0;  // Identity
            end
        end else if (swap) begin
            // No-op when the diagonal is already nonzero
            for (int k = 0; k < matDim; k++) begin
                aMat[elemAt(pivotCol, idx_t'(k))] <= aMat[elemAt(pivotRow, idx_t'(k))];
                aMat[elemAt(pivotRow, idx_t'(k))] <= aMat[elemAt(pivotCol, idx_t'(k))];
                iMat[elemAt(pivotCol, idx_t'(k))] <= iMat[elemAt(pivotRow, idx_t'(k))];
                iMat[elemAt(pivotRow, idx_t'(k))] <= iMat[elemAt(pivotCol, idx_t'(k))];
            end
        end else if (wrEn) begin
            aMat[elemAt(rowSel, elemCol)] <= aNew;
            iMat[elemAt(rowSel, elemCol)] <= iNew;
        end
    end

    // Result registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            matrixOut <= '0;
            singular  <= 1'b0;
        end else if (capture) begin
            singular <= singularOut;
            for (int i = 0; i < matElems; i++)
                matrixOut[i] <= singularOut ? '0 : iMat[i];  // Zeros on singular
        end
    end

    // Swap leaves a nonzero pivot on the diagonal
    assert property (@(posedge clk) disable iff (rst) swap |=> (diagElem != '0));

endmodule

// ==== hdl/rowAlu.sv ====
// Row arithmetic for Gauss-Jordan steps
// Normalize divides by the latched pivot, eliminate subtracts
// the pivot row scaled by the latched factor, A and I together

`timescale 1ns/1ps

module rowAlu (
    input  logic           clk,
    input  logic           rst,
    input  logic           latchPivot,
    input  logic           latchFactor,
    input  ctlPkg::aluOp_t aluOp,
    input  mtxPkg::qElem_t diagElem,
    input  mtxPkg::qElem_t colElem,
    input  mtxPkg::qElem_t srcA,
    input  mtxPkg::qElem_t srcI,
    input  mtxPkg::qElem_t dstA,
    input  mtxPkg::qElem_t dstI,
    output mtxPkg::qElem_t aNew,
    output mtxPkg::qElem_t iNew
);
    import mtxPkg::*;
    import ctlPkg::*;

    qElem_t pivotReg;    // p, held through the normalize pass
    qElem_t factorReg;   // f, held through one target row
    qWide_t divisor;
    qWide_t aQuot, iQuot;
    qWide_t aDiff, iDiff;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pivotReg  <= '0;
            factorReg <= '0;
        end else begin
            if (latchPivot)
                pivotReg <= diagElem;
            if (latchFactor)
                factorReg <= colElem;
        end
    end

    // ========================================
    // Normalize and eliminate paths
    // ========================================
    always_comb begin
        divisor = (pivotReg == '0) ? qWide_t'(1) : qWide_t'(pivotReg);  // Idle guard
        // Sign-extend, scale up, signed divide truncating toward zero
        aQuot = (qWide_t'(dstA) <<< fracBits) / divisor;
        iQuot = (qWide_t'(dstI) <<< fracBits) / divisor;
        // Full 64-bit product, rescaled back to Q20.12
        aDiff = qWide_t'(dstA) - ((qWide_t'(srcA) * qWide_t'(factorReg)) >>> fracBits);
        iDiff = qWide_t'(dstI) - ((qWide_t'(srcI) * qWide_t'(factorReg)) >>> fracBits);
    end

    // Truncate to element width
    assign aNew = (aluOp == opElim) ? qElem_t'(aDiff) : qElem_t'(aQuot);
    assign iNew = (aluOp == opElim) ? qElem_t'(iDiff) : qElem_t'(iQuot);

    // Pivot search upstream must hand over a nonzero p
    assert property (@(posedge clk) disable iff (rst)
        latchPivot |=> (aluOp == opNorm) && (pivotReg != '0));

endmodule

// ==== hdl/matInvTop.sv ====
// 4x4 Gauss-Jordan matrix inverter, Q20.12 fixed point
// Start/done level handshake, packed input and output matrices
// Singular flag raised when a pivot column has no nonzero entry

`timescale 1ns/1ps

module matInvTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,      // Request, held until done seen
    input  mtxPkg::matFlat_t matrixIn,   // Sampled when start is accepted
    output mtxPkg::matFlat_t matrixOut,  // Inverse, zero when singular
    output logic             done,
    output logic             singular
);
    import mtxPkg::*;
    import ctlPkg::*;

    // Controller strobes
    logic   load, swap, latchPivot, latchFactor, wrEn, capture, singularOut;
    logic   cntClear, kStep, rowStep, colStep;
    aluOp_t aluOp;

    // Counter state and flags
    idx_t pivotCol, targetRow, elemCol;
    logic kLast, rowLast, colLast;

    // Datapath
    logic   pivotFound;
    qElem_t diagElem, colElem, srcA, srcI, dstA, dstI;
    qElem_t aNew, iNew;

    // ========================================
    // Control
    // ========================================
    invControl uCtl (
        .clk, .rst, .start, .pivotFound, .kLast, .rowLast, .colLast,
        .load, .swap, .latchPivot, .latchFactor, .wrEn, .capture, .singularOut,
        .cntClear, .kStep, .rowStep, .colStep, .done, .aluOp
    );

    indexCounter uCnt (
        .clk, .rst, .cntClear, .kStep, .rowStep, .colStep,
        .pivotCol, .targetRow, .elemCol, .kLast, .rowLast, .colLast
    );

    // ========================================
    // Datapath
    // ========================================
    augMatrix uMat (
        .clk, .rst, .load, .swap, .wrEn, .capture, .singularOut, .aluOp,
        .matrixIn, .pivotCol, .targetRow, .elemCol, .aNew, .iNew,
        .pivotFound, .diagElem, .colElem, .srcA, .srcI, .dstA, .dstI,
        .matrixOut, .singular
    );

    rowAlu uAlu (
        .clk, .rst, .latchPivot, .latchFactor, .aluOp,
        .diagElem, .colElem, .srcA, .srcI, .dstA, .dstI,
        .aNew, .iNew
    );

endmodule

// ==== verif/matInvModel.svh ====
// Reference model for the 4x4 Gauss-Jordan inverter
// Q20.12 normalize and eliminate steps with pivot row swap,
// singular exit when a pivot column has no nonzero entry

`ifndef MAT_INV_MODEL_SVH
`define MAT_INV_MODEL_SVH

// Working copy of the augmented matrix, row-major
logic signed [31:0] refA [16];
logic signed [31:0] refI [16];

// Element times 2^12 over the pivot, truncating toward zero
function automatic logic signed [31:0] normElem(input logic signed [31:0] x,
                                               input logic signed [31:0] p);
    logic signed [63:0] num;
    logic signed [63:0] den;
    num = x;                          // Sign-extended to 64 bits
    den = p;
    num = (num <<< fracBits) / den;
    return num[31:0];
endfunction

// Target element minus rescaled product of pivot row element and factor
function automatic logic signed [31:0] elimElem(input logic signed [31:0] dst,
                                               input logic signed [31:0] src,
                                               input logic signed [31:0] f);
    logic signed [63:0] prod;
    logic signed [63:0] fw;
    logic signed [63:0] diff;
    prod = src;
    fw   = f;
    prod = (prod * fw) >>> fracBits;  // Arithmetic shift back to Q20.12
    diff = dst;
    diff = diff - prod;
    return diff[31:0];
endfunction

task automatic invertReference(input mtxPkg::matFlat_t m, output mtxPkg::matFlat_t res,
                               output logic sing);
    logic signed [31:0] t;
    logic signed [31:0] p;
    logic signed [31:0] f;
    int                 pr;
    sing = 1'b0;
    res  = '0;
    for (int i = 0; i < 16; i++) begin
        refA[i] = m[i];
        refI[i] = ((i / 4) == (i % 4)) ? qOne : 0;  // Identity half
    end
    for (int c = 0; c < 4 && !sing; c++) begin
        pr = -1;
        for (int r = 3; r >= c; r--)
            if (refA[r*4+c] != 0) pr = r;           // Smallest nonzero row wins
        if (pr < 0) begin
            sing = 1'b1;
        end else begin
            for (int k = 0; k < 4; k++) begin       // Swap, no-op when pr == c
                t = refA[c*4+k];
                refA[c*4+k] = refA[pr*4+k];
                refA[pr*4+k] = t;
                t = refI[c*4+k];
                refI[c*4+k] = refI[pr*4+k];
                refI[pr*4+k] = t;
            end
            p = refA[c*4+c];
            for (int k = 0; k < 4; k++) begin
                refA[c*4+k] = normElem(refA[c*4+k], p);
                refI[c*4+k] = normElem(refI[c*4+k], p);
            end
            for (int r = 0; r < 4; r++) begin
                if (r != c) begin
                    f = refA[r*4+c];                // Factor taken before the row pass
                    for (int k = 0; k < 4; k++) begin
                        refA[r*4+k] = elimElem(refA[r*4+k], refA[c*4+k], f);
                        refI[r*4+k] = elimElem(refI[r*4+k], refI[c*4+k], f);
                    end
                end
            end
        end
    end
    if (!sing)
        for (int i = 0; i < 16; i++) res[i] = refI[i];
endtask

`endif

// ==== verif/matInvTb.sv ====
// Testbench for the 4x4 matrix inverter
// Random matrices from a fixed seed, checked against the reference model,
// plus swap, singular and start/done handshake cases

`timescale 1ns/1ps

module matInvTb;
    import mtxPkg::*;

    localparam int runCount      = 20;   // Diagonally dominant runs
    localparam int swapRuns      = 10;
    localparam int singularRuns  = 6;
    localparam int timeoutCycles = 500;  // Longest run is about 90 cycles

    logic     clk, rst, start, done, singular;
    matFlat_t matrixIn, matrixOut;
    integer   seed;

    `include "matInvModel.svh"

    matInvTop u_dut (
        .clk, .rst, .start, .matrixIn, .matrixOut, .done, .singular
    );

    always #5 clk = ~clk;  // 10 ns period

    // ========================================
    // Reporting and waits
    // ========================================
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
            abortRun($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic waitDone(input logic level);  // Sampled on the falling edge
        int cycles;
        cycles = 0;
        while (done !== level) begin
            if (cycles == timeoutCycles)
                abortRun($sformatf("Timed out waiting for done to become %0d", level));
            else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================
    function automatic matFlat_t diagDominant();
        matFlat_t m;
        int       mag;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                mag = 6 * qOne + ($random(seed) & 16'h3fff);  // Beats 3 x 2.0
                if (r == c)
                    m[r*4+c] = ($random(seed) & 1) ? -mag : mag;
                else
                    m[r*4+c] = $random(seed) % (2 * qOne);    // Below 2.0
            end
        end
        return m;
    endfunction

    // Row permutation of a sparse dominant matrix, A[0][0] forced to zero
    function automatic matFlat_t permutedRows();
        matFlat_t d, m;
        int       perm [4];
        int       j, t;
        d = diagDominant();
        for (int i = 0; i < 16; i++)
            if (((i / 4) != (i % 4)) && ($random(seed) & 1)) d[i] = '0;
        for (int i = 0; i < 4; i++) perm[i] = i;
        for (int i = 3; i > 0; i--) begin                     // Fisher-Yates
            j = ($random(seed) & 32'h7fff_ffff) % (i + 1);
            t = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
        if (perm[0] == 0) begin
            perm[0] = perm[1];
            perm[1] = 0;
        end
        d[perm[0]*4] = '0;                                    // Needs a swap at column 0
        for (int i = 0; i < 4; i++)
            for (int k = 0; k < 4; k++) m[i*4+k] = d[perm[i]*4+k];
        return m;
    endfunction

    function automatic matFlat_t singularMatrix(input bit zeroCol);
        matFlat_t m;
        int       sel;
        for (int i = 0; i < 16; i++) m[i] = $random(seed) % (8 * qOne);
        sel = $random(seed) & 3;
        if (zeroCol) begin
            for (int r = 0; r < 4; r++) m[r*4+sel] = '0;
        end else begin
            if (sel == 0) sel = 1;
            m[0] = qOne;                                      // Pivot 1.0 keeps the copy exact
            for (int k = 0; k < 4; k++) m[sel*4+k] = m[k];
        end
        return m;
    endfunction

    // ========================================
    // Request and check
    // ========================================
    task automatic runRequest(input matFlat_t m, input int holdCycles);
        matFlat_t expOut;
        logic     expSing;
        @(posedge clk);
        start    <= 1'b1;
        matrixIn <= m;
        @(posedge clk);
        matrixIn <= diagDominant();   // Input only matters on the accept edge
        waitDone(1'b1);
        invertReference(m, expOut, expSing);
        for (int h = 0; h <= holdCycles; h++) begin
            if (h > 0) begin
                @(negedge clk);
                checkValue("done", done, 1'b1);  // Held while start stays high
            end
            checkValue("singular", singular, expSing);
            for (int i = 0; i < matElems; i++)
                checkValue($sformatf("matrixOut[%0d]", i), matrixOut[i], expOut[i]);
        end
        @(posedge clk);
        start <= 1'b0;
        waitDone(1'b0);
    endtask

    initial begin
        matFlat_t ident;
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        matrixIn = '0;
        seed     = 32'ha5af_752f;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("done", done, 1'b0);
        checkValue("singular", singular, 1'b0);
        ident = '0;
        for (int r = 0; r < 4; r++) ident[r*5] = qOne;
        runRequest(ident, 0);
        for (int i = 0; i < matElems; i++)  // Identity maps to itself
            checkValue($sformatf("matrixOut[%0d]", i), matrixOut[i], (i % 5 == 0) ? qOne : 0);
        for (int n = 0; n < runCount; n++) runRequest(diagDominant(), 0);
        for (int n = 0; n < swapRuns; n++) runRequest(permutedRows(), 0);
        for (int n = 0; n < singularRuns; n++) begin
            runRequest(singularMatrix(n[0]), 0);
            checkValue("singular", singular, 1'b1);
        end
        // Long hold, then a fresh request
        runRequest(diagDominant(), 1 + ($random(seed) & 15));
        runRequest(permutedRows(), 0);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
hdl/mtxPkg.sv
hdl/ctlPkg.sv
hdl/invControl.sv
hdl/indexCounter.sv
hdl/augMatrix.sv
hdl/rowAlu.sv
hdl/matInvTop.sv
verif/matInvTb.sv

// ==== Bender.yml ====
package:
  name: mat_inv

sources:
  - files:
      - hdl/mtxPkg.sv
      - hdl/ctlPkg.sv
      - hdl/invControl.sv
      - hdl/indexCounter.sv
      - hdl/augMatrix.sv
      - hdl/rowAlu.sv
      - hdl/matInvTop.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/matInvTb.sv
